/* project.f */
source/isa_pkg.sv
source/fp64_pkg.sv
source/fpu_arg_if.sv
source/change_det.sv
source/fp_cvt.sv
source/fp_misc.sv
source/fpu64.sv
test/clk_gen.sv
test/fpu64_props.sv
test/fpu64_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the float unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module fpu64_tb -f project.f -o sim
status=0
./obj_dir/sim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Something failed" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

/* source/change_det.sv */
// Flags a change of a watched vector against the value it had on the previous clock edge
module change_det #(
	parameter int WID = 64
) (
	input  logic           clk,
	input  logic           rst,
	input  logic [WID-1:0] i,
	output logic           cd
);

	// Copy of the input as seen on the last edge
	logic [WID-1:0] prev;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			prev <= '0;
		else
			prev <= i;
	end

	// Combinational, so the change is visible in the same cycle the new value arrives
	// A zero input straight after reset counts as no change
	assign cd = (i != prev);

endmodule

/* source/fp64_pkg.sv */
// Double-precision field types, constants and unit latencies, imported by the arithmetic units and top level
package fp64_pkg;

	// ====================================================================
	// Field layout of an IEEE binary64 word
	// ====================================================================

	localparam int EXP_W = 11;
	localparam int MAN_W = 52;

	// Same word type carries floats and two's complement integers
	typedef logic [63:0]      f64_t;
	typedef logic [EXP_W-1:0] exp_t;
	typedef logic [MAN_W-1:0] man_t;

	localparam exp_t EXP_BIAS = 11'd1023;

	// Saturation values of the float to integer converter
	localparam f64_t INT64_MAX = 64'h7FFF_FFFF_FFFF_FFFF;
	localparam f64_t INT64_MIN = 64'h8000_0000_0000_0000;

	// ====================================================================
	// Compare mask bits, all other mask bits read zero
	// ====================================================================

	localparam int CMP_EQ = 0;
	localparam int CMP_LT = 1;
	localparam int CMP_LE = 2;
	localparam int CMP_UN = 4;

	// Cycles from an operand change until the registered units hold their result
	localparam int LAT_TRUNC = 1;
	localparam int LAT_CVT   = 2;

endpackage

/* source/fp_cvt.sv */
// Two-stage float to signed integer and signed integer to float converters fed by the operand bundle
module fp_cvt
	import isa_pkg::*, fp64_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	fpu_arg_if.unit       args,
	output f64_t          f2i,
	output f64_t          i2f
);

	// Counts the leading zeros of a 64-bit word and gives 64 for a zero word
	function automatic logic [6:0] lzc64(input f64_t v);
		logic [6:0] n;
		n = 7'd64;
		// Highest set bit wins because it is visited last
		for (int k = 0; k < 64; k++)
			if (v[k])
				n = 7'(63 - k);
		return n;
	endfunction

	// ====================================================================
	// Float to integer stage one unpacks and aligns
	// ====================================================================

	exp_t       f_exp;
	man_t       f_man;
	logic [5:0] f_sh;
	logic       f_nan_d;
	logic       f_ovf_d;
	f64_t       f_mag_d;

	logic       f1_sign;
	logic       f1_nan;
	logic       f1_ovf;
	f64_t       f1_mag;

	assign f_exp = args.a[62:52];
	assign f_man = args.a[51:0];
	assign f_nan_d = (&f_exp) && (|f_man);
	// Infinities, NaN and anything else of magnitude 2^63 or more do not fit
	assign f_ovf_d = (f_exp >= exp_t'(EXP_BIAS + 63));
	// The unbiased exponent is only meaningful in the 0 to 62 range used below
	assign f_sh = 6'(f_exp - EXP_BIAS);

	always_comb begin
		f_mag_d = '0;
		// Below one the integer part is zero, so the default stands
		if (f_exp >= EXP_BIAS && !f_ovf_d) begin
			if (f_sh >= 6'd52)
				f_mag_d = {11'd0, 1'b1, f_man} << (f_sh - 6'd52);
			else
				f_mag_d = {11'd0, 1'b1, f_man} >> (6'd52 - f_sh);
		end
	end

	// Loads only on an operand change, and then holds for repeated operands
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			f1_sign <= 1'b0;
			f1_nan  <= 1'b0;
			f1_ovf  <= 1'b0;
			f1_mag  <= '0;
		end else if (args.ld) begin
			f1_sign <= args.a[63];
			f1_nan  <= f_nan_d;
			f1_ovf  <= f_ovf_d;
			f1_mag  <= f_mag_d;
		end
	end

	// Stage two applies the sign or saturates
	// -2^63 lands on INT64_MIN through the overflow path, which is the exact value anyway
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			f2i <= '0;
		else if (f1_nan)
			f2i <= INT64_MAX;
		else if (f1_ovf)
			f2i <= f1_sign ? INT64_MIN : INT64_MAX;
		else
			f2i <= f1_sign ? -f1_mag : f1_mag;
	end

	// ====================================================================
	// Integer to float stage one takes the magnitude and leading zeros
	// ====================================================================

	f64_t       i_mag_d;
	logic       i1_sign;
	f64_t       i1_mag;
	logic [6:0] i1_lzc;

	// The most negative integer maps onto 2^63, which is still correct as an unsigned magnitude
	assign i_mag_d = args.a[63] ? -args.a : args.a;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			i1_sign <= 1'b0;
			i1_mag  <= '0;
			i1_lzc  <= '0;
		end else if (args.ld) begin
			i1_sign <= args.a[63];
			i1_mag  <= i_mag_d;
			i1_lzc  <= lzc64(i_mag_d);
		end
	end

	f64_t        i_norm;
	logic        i_guard;
	logic        i_sticky;
	logic        i_inc;
	logic [53:0] i_sum;
	exp_t        i_exp;

	// Normalized so the leading one sits in bit 63
	// Bits 63..11 are the 53 kept bits
	assign i_norm = i1_mag << i1_lzc;
	assign i_guard = i_norm[10];
	assign i_sticky = |i_norm[9:0];

	// Round increment from guard, sticky, sign and the kept LSB
	always_comb begin
		case (args.rm)
			RM_RTZ: i_inc = 1'b0;
			RM_RDN: i_inc = i1_sign & (i_guard | i_sticky);
			RM_RUP: i_inc = ~i1_sign & (i_guard | i_sticky);
			RM_RMM: i_inc = i_guard;
			default: i_inc = i_guard & (i_sticky | i_norm[11]);
		endcase
	end

	// A carry out of the significand means it rolled over to 2.0, so bump the exponent
	assign i_sum = {1'b0, i_norm[63:11]} + 54'(i_inc);
	assign i_exp = exp_t'(EXP_BIAS + 63) - exp_t'(i1_lzc) + exp_t'(i_sum[53]);

	// After a carry the sum is exactly 2^53, so its fraction bits already read zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			i2f <= '0;
		else if (i1_mag == '0)
			i2f <= '0;
		else
			i2f <= {i1_sign, i_exp, i_sum[51:0]};
	end

endmodule

/* source/fp_misc.sv */
// Combinational compare and classification of the operand pair plus a registered truncation toward zero
module fp_misc
	import fp64_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	fpu_arg_if.unit  args,
	output f64_t     cmp,
	output f64_t     trunc,
	output logic     is_nan,
	output logic     is_finite
);

	// ====================================================================
	// Field unpacking
	// ====================================================================

	exp_t        a_exp;
	exp_t        b_exp;
	man_t        a_man;
	man_t        b_man;
	logic [62:0] a_mag;
	logic [62:0] b_mag;
	logic        a_nan;
	logic        b_nan;
	logic        both_zero;
	logic        eq;
	logic        lt;

	assign a_exp = args.a[62:52];
	assign b_exp = args.b[62:52];
	assign a_man = args.a[51:0];
	assign b_man = args.b[51:0];
	// Magnitude without the sign orders like an unsigned integer
	assign a_mag = args.a[62:0];
	assign b_mag = args.b[62:0];

	assign a_nan = (&a_exp) && (|a_man);
	assign b_nan = (&b_exp) && (|b_man);

	// ====================================================================
	// Compare mask
	// ====================================================================

	// Plus and minus zero compare equal
	assign both_zero = (a_mag == '0) && (b_mag == '0);
	assign eq = (args.a == args.b) || both_zero;

	always_comb begin
		if (both_zero)
			lt = 1'b0;
		else if (args.a[63] != args.b[63])
			lt = args.a[63];
		else if (args.a[63])
			// Both negative, the larger magnitude is the smaller value
			lt = a_mag > b_mag;
		else
			lt = a_mag < b_mag;
	end

	// A NaN on either side leaves only the unordered bit set
	always_comb begin
		cmp = '0;
		if (a_nan || b_nan) begin
			cmp[CMP_UN] = 1'b1;
		end else begin
			cmp[CMP_EQ] = eq;
			cmp[CMP_LT] = lt;
			cmp[CMP_LE] = lt | eq;
		end
	end

	// Classification looks at a only
	assign is_nan = a_nan;
	assign is_finite = ~&a_exp;

	// ====================================================================
	// Truncation toward zero
	// ====================================================================

	logic [5:0] drop;
	man_t       keep;
	f64_t       trunc_d;

	// Number of fraction bits below the binary point, 1 to 52 in the range that uses it
	assign drop = 6'(exp_t'(EXP_BIAS + MAN_W) - a_exp);
	// At drop of 52 the shift overflows to zero, and the mask clears the whole fraction
	assign keep = ~((man_t'(1) << drop) - man_t'(1));

	always_comb begin
		if (a_exp < EXP_BIAS)
			trunc_d = {args.a[63], 63'd0};
		else if (a_exp < exp_t'(EXP_BIAS + MAN_W))
			trunc_d = {args.a[63:52], a_man & keep};
		else
			// Already integral, infinities and NaN pass through too
			trunc_d = args.a;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			trunc <= '0;
		else if (args.ld)
			trunc <= trunc_d;
	end

endmodule

/* source/fpu64.sv */
// Top level of the double-precision float unit, decodes the instruction and reports done by latency
module fpu64
	import isa_pkg::*, fp64_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         idle,
	input  instruction_t ir,
	input  round_mode_t  rm,
	input  f64_t         a,
	input  f64_t         b,
	output f64_t         o,
	output logic         done
);

	localparam int ARG_W = 2 * $bits(f64_t);

	logic       cd;
	logic [7:0] cnt_q;
	logic [7:0] cnt;
	logic [7:0] lat;
	f64_t       f2i;
	f64_t       i2f;
	f64_t       cmp;
	f64_t       trunc;
	logic       is_nan;
	logic       is_finite;

	// ====================================================================
	// Operand bundle and change detection
	// ====================================================================

	fpu_arg_if args_i ();

	assign args_i.a  = a;
	assign args_i.b  = b;
	assign args_i.rm = rm;
	assign args_i.ld = cd;

	// New operands restart the latency count and load the pipelines
	change_det #(.WID(ARG_W)) cd_i (
		.clk (clk),
		.rst (rst),
		.i   ({a, b}),
		.cd  (cd)
	);

	fp_cvt cvt_i (
		.clk  (clk),
		.rst  (rst),
		.args (args_i.unit),
		.f2i  (f2i),
		.i2f  (i2f)
	);

	fp_misc misc_i (
		.clk       (clk),
		.rst       (rst),
		.args      (args_i.unit),
		.cmp       (cmp),
		.trunc     (trunc),
		.is_nan    (is_nan),
		.is_finite (is_finite)
	);

	// ====================================================================
	// Latency counter
	// ====================================================================

	// Reads zero in the change cycle itself, so the count equals cycles since the change
	assign cnt = cd ? 8'd0 : cnt_q;

	// Sticks at all ones so long-held operands stay done
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			cnt_q <= '0;
		else if (cnt != 8'hFF)
			cnt_q <= cnt + 8'd1;
		else
			cnt_q <= cnt;
	end

	// ====================================================================
	// Decode, result select and latency class
	// ====================================================================

	always_comb begin
		o = '0;
		lat = '0;
		if (ir.opcode == OP_FLT2) begin
			case (ir.func3)
				FN_FLT1:
					case (ir.func1)
						FN_FABS:   o = {1'b0, a[62:0]};
						FN_FNEG:   o = {~a[63], a[62:0]};
						FN_ISNAN:  o = {63'd0, is_nan};
						FN_FINITE: o = {63'd0, is_finite};
						FN_FTOI: begin
							o = f2i;
							lat = 8'(LAT_CVT);
						end
						FN_ITOF: begin
							o = i2f;
							lat = 8'(LAT_CVT);
						end
						FN_FTRUNC: begin
							o = trunc;
							lat = 8'(LAT_TRUNC);
						end
						default:   o = '0;
					endcase
				FN_FSEQ:  o = {63'd0, cmp[CMP_EQ]};
				// True for unordered operands as well
				FN_FSNE:  o = {63'd0, ~cmp[CMP_EQ]};
				FN_FSLT:  o = {63'd0, cmp[CMP_LT]};
				FN_FSLE:  o = {63'd0, cmp[CMP_LE]};
				FN_FCMP:  o = cmp;
				// Sign comes from a, magnitude from b
				FN_SGNJ:  o = {a[63], b[62:0]};
				FN_SGNJN: o = {~a[63], b[62:0]};
				FN_SGNJX: o = {a[63] ^ b[63], b[62:0]};
				default:  o = '0;
			endcase
		end
	end

	// Combinational operations have a latency of zero and are done at once
	assign done = ~idle && (cnt >= lat);

endmodule

/* source/fpu_arg_if.sv */
// Operand bundle from the float unit top level to its arithmetic units, connected through modports
interface fpu_arg_if
	import isa_pkg::*, fp64_pkg::*;
();

	// Operands as presented on the top level ports
	f64_t        a;
	f64_t        b;
	// Rounding mode, only the integer to float path reads it
	round_mode_t rm;
	// High for one cycle whenever the operand pair changes
	logic        ld;

	// Top level side drives everything
	modport src (
		output a, b, rm, ld
	);

	// Units only read the bundle
	modport unit (
		input a, b, rm, ld
	);

endinterface

/* source/isa_pkg.sv */
// Instruction word layout and operation codes of the float unit, imported by the decoder and testbench
package isa_pkg;

	// Major opcode in the low seven bits of every instruction word
	// Only the two-operand float group belongs to this unit
	typedef enum logic [6:0] {
		OP_NOP  = 7'h00,
		OP_FLT2 = 7'h4C
	} opcode_t;

	// Upper function field picks a compare, a sign injection, or the one-operand group
	typedef enum logic [4:0] {
		FN_FLT1  = 5'h01,
		FN_FSEQ  = 5'h08,
		FN_FSNE  = 5'h09,
		FN_FSLT  = 5'h0A,
		FN_FSLE  = 5'h0B,
		FN_FCMP  = 5'h0C,
		FN_SGNJ  = 5'h10,
		FN_SGNJN = 5'h11,
		FN_SGNJX = 5'h12
	} func3_t;

	// Lower function field selects the operation inside the one-operand group
	typedef enum logic [4:0] {
		FN_FABS   = 5'h00,
		FN_FNEG   = 5'h01,
		FN_FTOI   = 5'h02,
		FN_ITOF   = 5'h03,
		FN_ISNAN  = 5'h04,
		FN_FINITE = 5'h05,
		FN_FTRUNC = 5'h06
	} func1_t;

	// Register numbers sit between the function fields and the opcode
	// The unit gets its operands on ports, so it never looks at them
	typedef struct packed {
		func3_t      func3;
		func1_t      func1;
		logic [4:0]  rb;
		logic [4:0]  ra;
		logic [4:0]  rt;
		opcode_t     opcode;
	} instruction_t;

	// Rounding mode field, RISC-V encoding
	// Codes 5 to 7 fall back to nearest-even in the converter
	typedef logic [2:0] round_mode_t;

	localparam round_mode_t RM_RNE = 3'd0;
	localparam round_mode_t RM_RTZ = 3'd1;
	localparam round_mode_t RM_RDN = 3'd2;
	localparam round_mode_t RM_RUP = 3'd3;
	localparam round_mode_t RM_RMM = 3'd4;

endpackage

/* test/clk_gen.sv */
// Testbench clock and reset source, 10 ns clock with reset held for the first 16 rising edges
module clk_gen (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Released on an edge so the design leaves reset in step with the stimulus
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* test/fpu64_props.sv */
// Concurrent checks on idle, done and the latency counter, bound into the float unit top level
module fpu64_props
	import isa_pkg::*;
(
	input logic         clk,
	input logic         rst,
	input logic         idle,
	input logic         done,
	input logic         cd,
	input logic [7:0]   cnt,
	input instruction_t ir
);

	timeunit 1ns;
	timeprecision 100ps;

	logic is_cvt;

	// Both conversions share the two-cycle latency class
	assign is_cvt = (ir.opcode == OP_FLT2) && (ir.func3 == FN_FLT1) &&
		((ir.func1 == FN_FTOI) || (ir.func1 == FN_ITOF));

	done_idle_a: assert property (@(posedge clk) disable iff (rst) idle |-> !done)
		else $error("done is high while idle is high");

	// The pipelines only load on the change edge, so done must wait
	cvt_change_a: assert property (@(posedge clk) disable iff (rst) (is_cvt && cd) |-> !done)
		else $error("conversion reports done in an operand change cycle");

	// Saturating count, so without a change it can only hold or grow
	cnt_order_a: assert property (@(posedge clk) disable iff (rst) !cd |-> cnt >= $past(cnt))
		else $error("latency counter moved backwards without an operand change");

endmodule

/* test/fpu64_tb.sv */
// Random-stimulus testbench of the float unit, checks every result against a reference model
module fpu64_tb
	import isa_pkg::*, fp64_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_SIGN   = 200;
	localparam int N_CMP    = 120;
	localparam int N_DIR    = 6;
	localparam int N_TRUNC  = 100;
	localparam int N_F2I    = 100;
	localparam int N_I2F    = 40;
	localparam int N_REPEAT = 25;
	localparam int N_OPS    = 5 * N_SIGN + 7 * (N_CMP + N_DIR) + N_TRUNC + N_F2I +
		5 * N_I2F + 2 * N_REPEAT;
	// Every operation needs at most five cycles, eight leaves room
	localparam int LIMIT    = N_OPS * 8 + 16;

	// Zeros, infinities, NaN, one, half and large integral values
	localparam f64_t SPECIALS [12] = '{
		64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h7FF0_0000_0000_0000,
		64'hFFF0_0000_0000_0000, 64'h7FF8_0000_0000_0000, 64'h3FF0_0000_0000_0000,
		64'hBFF0_0000_0000_0000, 64'h43E0_0000_0000_0000, 64'hC3E0_0000_0000_0000,
		64'h4330_0000_0000_0001, 64'h3FE0_0000_0000_0000, 64'hC1E0_0000_0000_0000
	};
	// Directed compare pairs, opposite zeros, NaN on each side, equal infinities
	localparam f64_t DIR_X [N_DIR] = '{64'h0, 64'h8000_0000_0000_0000, 64'h7FF8_0000_0000_0000,
		64'h3FF0_0000_0000_0000, 64'h7FF0_0000_0000_0000, 64'hBFF0_0000_0000_0000};
	localparam f64_t DIR_Y [N_DIR] = '{64'h8000_0000_0000_0000, 64'h0, 64'h3FF0_0000_0000_0000,
		64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0000, 64'h3FF0_0000_0000_0000};

	logic         clk;
	logic         rst;
	logic         idle;
	instruction_t ir;
	round_mode_t  rm;
	f64_t         a;
	f64_t         b;
	f64_t         o;
	logic         done;

	logic [31:0]  rng_state = 32'h40c3_9953;
	int           checks = 0;
	int           errors = 0;
	int           base_checks = 0;
	int           base_errors = 0;
	int           cycle_count = 0;
	// Operand pair the DUT last saw, it matches the change detector after reset
	f64_t         last_a = '0;
	f64_t         last_b = '0;

	clk_gen clk_gen_i (
		.clk (clk),
		.rst (rst)
	);

	fpu64 dut_i (
		.clk  (clk),
		.rst  (rst),
		.idle (idle),
		.ir   (ir),
		.rm   (rm),
		.a    (a),
		.b    (b),
		.o    (o),
		.done (done)
	);

	bind fpu64 fpu64_props props_i (
		.clk  (clk),
		.rst  (rst),
		.idle (idle),
		.done (done),
		.cd   (cd),
		.cnt  (cnt),
		.ir   (ir)
	);

	// ======================================================================
	// Random operands
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic f64_t special_value();
		logic [3:0] idx;
		idx = 4'(rand32() % 32'd12);
		return SPECIALS[idx];
	endfunction

	// Exponent from 2^-24 to 2^103, so fractions, integers and overflow all show up
	function automatic f64_t near_int_value();
		logic [31:0] r;
		f64_t        v;
		r = rand32();
		v = {rand32(), rand32()};
		v[62:52] = EXP_BIAS - exp_t'(24) + exp_t'(r[6:0]);
		return v;
	endfunction

	function automatic f64_t pick_operand();
		logic [31:0] r;
		f64_t        v;
		r = rand32();
		case (r[1:0])
			2'd0: v = special_value();
			2'd1: v = {rand32(), rand32()};
			default: v = near_int_value();
		endcase
		return v;
	endfunction

	// Integers of every length, some short enough to convert exactly
	function automatic f64_t int_operand();
		logic [31:0] r;
		f64_t        v;
		r = rand32();
		v = {rand32(), rand32()} >> r[6:1];
		return r[7] ? -v : v;
	endfunction

	function automatic instruction_t make_ir(input func3_t f3, input func1_t f1);
		instruction_t ins;
		logic [31:0]  r;
		r = rand32();
		ins.opcode = OP_FLT2;
		ins.func3 = f3;
		ins.func1 = f1;
		// Register numbers are noise to the unit
		ins.rt = r[4:0];
		ins.ra = r[9:5];
		ins.rb = r[14:10];
		return ins;
	endfunction

	function automatic instruction_t random_ir();
		instruction_t ins;
		case (rand32() % 32'd16)
			32'd0: ins = make_ir(FN_FLT1, FN_FABS);
			32'd1: ins = make_ir(FN_FLT1, FN_FNEG);
			32'd2: ins = make_ir(FN_SGNJ, FN_FABS);
			32'd3: ins = make_ir(FN_SGNJN, FN_FABS);
			32'd4: ins = make_ir(FN_SGNJX, FN_FABS);
			32'd5: ins = make_ir(FN_FSEQ, FN_FABS);
			32'd6: ins = make_ir(FN_FSNE, FN_FABS);
			32'd7: ins = make_ir(FN_FSLT, FN_FABS);
			32'd8: ins = make_ir(FN_FSLE, FN_FABS);
			32'd9: ins = make_ir(FN_FCMP, FN_FABS);
			32'd10: ins = make_ir(FN_FLT1, FN_ISNAN);
			32'd11: ins = make_ir(FN_FLT1, FN_FINITE);
			32'd12: ins = make_ir(FN_FLT1, FN_FTOI);
			32'd13: ins = make_ir(FN_FLT1, FN_ITOF);
			32'd14: ins = make_ir(FN_FLT1, FN_FTRUNC);
			default: begin
				// Foreign opcode, the unit answers zero at once
				ins = make_ir(FN_FLT1, FN_FABS);
				ins.opcode = OP_NOP;
			end
		endcase
		return ins;
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic model_is_nan(input f64_t x);
		return (x[62:52] == 11'h7FF) && (x[51:0] != '0);
	endfunction

	// Ordering comes from the simulator's own double compare
	function automatic f64_t model_cmp(input f64_t x, input f64_t y);
		real  rx;
		real  ry;
		f64_t m;
		rx = $bitstoreal(x);
		ry = $bitstoreal(y);
		m = '0;
		if (model_is_nan(x) || model_is_nan(y)) begin
			m[CMP_UN] = 1'b1;
		end else begin
			m[CMP_EQ] = (rx == ry);
			m[CMP_LT] = (rx < ry);
			m[CMP_LE] = (rx <= ry);
		end
		return m;
	endfunction

	function automatic f64_t model_trunc(input f64_t x);
		exp_t e;
		int   fbits;
		e = x[62:52];
		if (e == 11'h7FF)
			return x;
		if (e < EXP_BIAS)
			return {x[63], 63'd0};
		// Fraction bits that sit below the binary point
		fbits = int'(EXP_BIAS) + MAN_W - int'(e);
		if (fbits <= 0)
			return x;
		return (x >> fbits) << fbits;
	endfunction

	function automatic f64_t model_f2i(input f64_t x);
		exp_t e;
		int   sh;
		f64_t m;
		e = x[62:52];
		if (model_is_nan(x))
			return INT64_MAX;
		if (int'(e) >= int'(EXP_BIAS) + 63)
			return x[63] ? INT64_MIN : INT64_MAX;
		if (e < EXP_BIAS)
			return '0;
		sh = int'(e) - int'(EXP_BIAS) - MAN_W;
		m = {11'd0, 1'b1, x[51:0]};
		m = (sh >= 0) ? (m << sh) : (m >> (-sh));
		return x[63] ? -m : m;
	endfunction

	function automatic f64_t model_i2f(input f64_t v, input round_mode_t mode);
		logic neg;
		logic inc;
		f64_t m;
		f64_t kept;
		f64_t rem;
		f64_t half;
		int   p;
		int   sh;
		exp_t e;
		neg = v[63];
		m = neg ? -v : v;
		if (m == '0)
			return '0;
		p = 0;
		for (int k = 0; k < 64; k++)
			if (m[k])
				p = k;
		e = exp_t'(int'(EXP_BIAS) + p);
		if (p <= MAN_W) begin
			kept = m << (MAN_W - p);
			return {neg, e, kept[51:0]};
		end
		// Split into the 53 kept bits and the discarded remainder
		sh = p - MAN_W;
		kept = m >> sh;
		rem = m - (kept << sh);
		half = f64_t'(1) << (sh - 1);
		case (mode)
			RM_RTZ: inc = 1'b0;
			RM_RDN: inc = neg && (rem != '0);
			RM_RUP: inc = !neg && (rem != '0);
			RM_RMM: inc = (rem >= half);
			default: inc = (rem > half) || ((rem == half) && kept[0]);
		endcase
		kept = kept + f64_t'(inc);
		if (kept[53]) begin
			e = e + exp_t'(1);
			kept = kept >> 1;
		end
		return {neg, e, kept[51:0]};
	endfunction

	function automatic f64_t expected_result(input instruction_t ins, input round_mode_t mode,
			input f64_t x, input f64_t y);
		f64_t m;
		f64_t r;
		m = model_cmp(x, y);
		r = '0;
		if (ins.opcode == OP_FLT2) begin
			case (ins.func3)
				FN_FLT1:
					case (ins.func1)
						FN_FABS: r = {1'b0, x[62:0]};
						FN_FNEG: r = {~x[63], x[62:0]};
						FN_ISNAN: r = f64_t'(model_is_nan(x));
						FN_FINITE: r = f64_t'(x[62:52] != 11'h7FF);
						FN_FTOI: r = model_f2i(x);
						FN_ITOF: r = model_i2f(x, mode);
						FN_FTRUNC: r = model_trunc(x);
						default: r = '0;
					endcase
				FN_FSEQ: r = f64_t'(m[CMP_EQ]);
				FN_FSNE: r = f64_t'(!m[CMP_EQ]);
				FN_FSLT: r = f64_t'(m[CMP_LT]);
				FN_FSLE: r = f64_t'(m[CMP_LE]);
				FN_FCMP: r = m;
				FN_SGNJ: r = {x[63], y[62:0]};
				FN_SGNJN: r = {~x[63], y[62:0]};
				FN_SGNJX: r = {x[63] ^ y[63], y[62:0]};
				default: r = '0;
			endcase
		end
		return r;
	endfunction

	function automatic int op_latency(input instruction_t ins);
		int lat;
		lat = 0;
		if (ins.opcode == OP_FLT2 && ins.func3 == FN_FLT1) begin
			if (ins.func1 == FN_FTOI || ins.func1 == FN_ITOF)
				lat = LAT_CVT;
			else if (ins.func1 == FN_FTRUNC)
				lat = LAT_TRUNC;
		end
		return lat;
	endfunction

	// ======================================================================
	// Checks and operation sequencing
	// ======================================================================

	task automatic check_word(input string name, input f64_t got, input f64_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// One issue, then one idle cycle, with done checked on every falling edge
	task automatic run_op(input instruction_t ins, input round_mode_t mode, input f64_t x,
			input f64_t y);
		int   lat;
		int   n;
		f64_t exp_o;
		lat = ({x, y} != {last_a, last_b}) ? op_latency(ins) : 0;
		exp_o = expected_result(ins, mode, x, y);
		@(posedge clk);
		idle <= 1'b0;
		ir <= ins;
		rm <= mode;
		a <= x;
		b <= y;
		last_a = x;
		last_b = y;
		n = 0;
		forever begin
			@(negedge clk);
			n++;
			if (n <= lat + 1)
				check_flag("done", done, n > lat);
			if (done)
				break;
		end
		check_word("o", o, exp_o);
		@(posedge clk);
		idle <= 1'b1;
		@(negedge clk);
		check_flag("done", done, 1'b0);
	endtask

	task automatic run_sign_set(input f64_t x, input f64_t y);
		run_op(make_ir(FN_FLT1, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FLT1, FN_FNEG), RM_RNE, x, y);
		run_op(make_ir(FN_SGNJ, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_SGNJN, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_SGNJX, FN_FABS), RM_RNE, x, y);
	endtask

	task automatic run_compare_set(input f64_t x, input f64_t y);
		run_op(make_ir(FN_FSEQ, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FSNE, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FSLT, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FSLE, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FCMP, FN_FABS), RM_RNE, x, y);
		run_op(make_ir(FN_FLT1, FN_ISNAN), RM_RNE, x, y);
		run_op(make_ir(FN_FLT1, FN_FINITE), RM_RNE, x, y);
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - base_checks, errors - base_errors);
		base_checks = checks;
		base_errors = errors;
	endtask

	// Watchdog for a done that never comes
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= LIMIT) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
			$display("Something failed");
			$finish;
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		instruction_t ins;
		round_mode_t  mode;
		f64_t         x;
		idle = 1'b1;
		ir = '0;
		rm = RM_RNE;
		a = '0;
		b = '0;

		// done stays low through reset and while idle afterwards
		do begin
			@(negedge clk);
			check_flag("done", done, 1'b0);
		end while (rst);
		repeat (4) begin
			@(negedge clk);
			check_flag("done", done, 1'b0);
		end
		end_test("reset and idle");

		for (int k = 0; k < N_SIGN; k++)
			run_sign_set(pick_operand(), pick_operand());
		end_test("sign operations");

		for (int k = 0; k < N_DIR; k++)
			run_compare_set(DIR_X[k], DIR_Y[k]);
		for (int k = 0; k < N_CMP; k++) begin
			x = pick_operand();
			// Every fourth pair compares a value with itself
			run_compare_set(x, (k % 4 == 0) ? x : pick_operand());
		end
		end_test("compare and classification");

		for (int k = 0; k < N_TRUNC; k++)
			run_op(make_ir(FN_FLT1, FN_FTRUNC), RM_RNE, pick_operand(), {rand32(), rand32()});
		end_test("truncation");

		for (int k = 0; k < N_F2I; k++)
			run_op(make_ir(FN_FLT1, FN_FTOI), RM_RNE, pick_operand(), {rand32(), rand32()});
		end_test("float to integer");

		for (int m = 0; m < 5; m++)
			for (int k = 0; k < N_I2F; k++)
				run_op(make_ir(FN_FLT1, FN_ITOF), round_mode_t'(m), int_operand(),
					{rand32(), rand32()});
		end_test("integer to float");

		// Second issue of the same work must be done at once
		for (int k = 0; k < N_REPEAT; k++) begin
			ins = random_ir();
			mode = round_mode_t'(rand32() % 32'd5);
			x = (ins.func1 == FN_ITOF) ? int_operand() : pick_operand();
			run_op(ins, mode, x, last_b + f64_t'(1));
			run_op(ins, mode, x, last_b);
		end
		end_test("repeated operands");

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
